/* rtl/mem_drv_pkg.sv */
/* Package mem_drv_pkg with the shared widths, request queue sizing
   and line memory size of the memory driver subsystem */

package mem_drv_pkg;

    // ==================================================
    // Data path widths
    // ==================================================

    // One cache line of payload
    localparam int LINE_BITS = 64;

    // Line address, so the platform memory holds 2**ADDR_BITS lines
    localparam int ADDR_BITS = 8;

    // Request tag returned with every response
    localparam int TAG_BITS = 6;

    // Request word is order flag, then address, then tag
    localparam int REQ_BITS = 1 + ADDR_BITS + TAG_BITS;

    // ==================================================
    // Request queues and line storage
    // ==================================================

    // Entries per channel queue
    localparam int REQ_FIFO_DEPTH = 8;
    localparam int REQ_PTR_BITS = $clog2(REQ_FIFO_DEPTH);
    localparam int REQ_CNT_BITS = $clog2(REQ_FIFO_DEPTH + 1);

    // Leaves room for the requests already between a rdy sample and the queue write
    localparam int REQ_ALMOST_FULL = REQ_FIFO_DEPTH - 3;

    // Number of lines in the platform memory
    localparam int MEM_LINES = 1 << ADDR_BITS;

endpackage

/* rtl/req_fifo.sv */
/* Module req_fifo: circular request queue with an occupancy count
   and an almost-full level for channel back-pressure */
`timescale 1ns/1ps

module req_fifo
#(
    parameter int WIDTH = mem_drv_pkg::REQ_BITS
)
(
    input  logic             clk,
    input  logic             reset_n,

    // Write side
    input  logic             push,
    input  logic [WIDTH-1:0] push_word,

    // Read side
    input  logic             pop,
    output logic [WIDTH-1:0] head_word,
    output logic             empty,
    output logic             almost_full
);

    logic [WIDTH-1:0]                     slots [mem_drv_pkg::REQ_FIFO_DEPTH];
    logic [mem_drv_pkg::REQ_PTR_BITS-1:0] wr_ptr;
    logic [mem_drv_pkg::REQ_PTR_BITS-1:0] rd_ptr;
    logic [mem_drv_pkg::REQ_CNT_BITS-1:0] count;

    // ==================================================
    // Storage
    // ==================================================

    // The depth is a power of two so both pointers wrap on their own
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            slots[wr_ptr] <= push_word;
        end
    end

    // Head is visible as soon as it is written
    assign head_word = slots[rd_ptr];

    // ==================================================
    // Pointers and occupancy
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign empty = (count == '0);

    // Senders stop at this level, so no overflow guard is needed
    assign almost_full = (count >= mem_drv_pkg::REQ_CNT_BITS'(mem_drv_pkg::REQ_ALMOST_FULL));

endmodule

/* rtl/rd_req_encoder.sv */
/* Module rd_req_encoder: tags accepted client reads and presents
   them as request words on the read channel */
`timescale 1ns/1ps

module rd_req_encoder
(
    input  logic                              clk,
    input  logic                              reset_n,

    // Client read request
    input  logic [mem_drv_pkg::ADDR_BITS-1:0] addr,
    input  logic                              check_order,
    input  logic                              enable,
    output logic                              rdy,

    // Read channel toward the line memory
    input  logic                              almost_full,
    output logic                              tx_valid,
    output logic [mem_drv_pkg::REQ_BITS-1:0]  tx_req
);

    logic [mem_drv_pkg::TAG_BITS-1:0] next_tag;
    logic                             accept;

    // The client sees the channel back-pressure directly
    assign rdy = ~almost_full;

    // An enable seen while rdy is low is dropped and spends no tag
    assign accept = enable & rdy;

    // Valid pulse follows the accepted enable by one cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tx_valid <= 1'b0;
            next_tag <= '0;
        end
        else
        begin
            tx_valid <= accept;
            // Tags wrap around after 2**TAG_BITS requests
            if (accept)
            begin
                next_tag <= next_tag + 1'b1;
            end
        end
    end

    // Request word from the top down holds order flag, line address, tag
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            tx_req <= {check_order, addr, next_tag};
        end
    end

endmodule

/* rtl/wr_req_encoder.sv */
/* Module wr_req_encoder: tags accepted client writes and presents
   them with their line data on the write channel */
`timescale 1ns/1ps

module wr_req_encoder
(
    input  logic                              clk,
    input  logic                              reset_n,

    // Client write request
    input  logic [mem_drv_pkg::ADDR_BITS-1:0] addr,
    input  logic [mem_drv_pkg::LINE_BITS-1:0] data,
    input  logic                              check_order,
    input  logic                              enable,
    output logic                              rdy,

    // Write channel toward the line memory
    input  logic                              almost_full,
    output logic                              tx_valid,
    output logic [mem_drv_pkg::REQ_BITS-1:0]  tx_req,
    output logic [mem_drv_pkg::LINE_BITS-1:0] tx_data
);

    logic [mem_drv_pkg::TAG_BITS-1:0] next_tag;
    logic                             accept;

    // Write side has its own back-pressure from the write queue
    assign rdy = ~almost_full;

    // Writes presented while rdy is low never reach the channel
    assign accept = enable & rdy;

    // Write tags count separately from read tags
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tx_valid <= 1'b0;
            next_tag <= '0;
        end
        else
        begin
            tx_valid <= accept;
            if (accept)
            begin
                next_tag <= next_tag + 1'b1;
            end
        end
    end

    // The order flag rides along for the platform
    // This memory already services writes strictly in request order
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            tx_req  <= {check_order, addr, next_tag};
            tx_data <= data;
        end
    end

endmodule

/* rtl/fiu_line_memory.sv */
/* Module fiu_line_memory: read and write request queues, ordered arbitration
   onto one line array port, and read responses and write acknowledges */
`timescale 1ns/1ps

module fiu_line_memory
(
    input  logic                              clk,
    input  logic                              reset_n,

    // Read channel c0
    input  logic                              c0_tx_valid,
    input  logic [mem_drv_pkg::REQ_BITS-1:0]  c0_tx_req,
    output logic                              c0_tx_almost_full,

    // Write channel c1
    input  logic                              c1_tx_valid,
    input  logic [mem_drv_pkg::REQ_BITS-1:0]  c1_tx_req,
    input  logic [mem_drv_pkg::LINE_BITS-1:0] c1_tx_data,
    output logic                              c1_tx_almost_full,

    // Responses back to the client
    output logic                              rd_rsp_valid,
    output logic [mem_drv_pkg::LINE_BITS-1:0] rd_rsp_data,
    output logic [mem_drv_pkg::TAG_BITS-1:0]  rd_rsp_tag,
    output logic                              wr_ack,
    output logic [mem_drv_pkg::TAG_BITS-1:0]  wr_ack_tag
);

    logic [mem_drv_pkg::REQ_BITS-1:0]                        rd_head;
    logic                                                    rd_empty;
    logic [mem_drv_pkg::REQ_BITS+mem_drv_pkg::LINE_BITS-1:0] wr_head;
    logic                                                    wr_empty;

    logic                              rd_order;
    logic [mem_drv_pkg::ADDR_BITS-1:0] rd_addr;
    logic [mem_drv_pkg::TAG_BITS-1:0]  rd_tag;
    logic [mem_drv_pkg::ADDR_BITS-1:0] wr_addr;
    logic [mem_drv_pkg::TAG_BITS-1:0]  wr_tag;
    logic [mem_drv_pkg::LINE_BITS-1:0] wr_line;

    logic                              sweeping;
    logic [mem_drv_pkg::ADDR_BITS-1:0] sweep_addr;
    logic                              rd_can;
    logic                              wr_can;
    logic                              read_first;
    logic                              do_read;
    logic                              do_write;

    logic                              mem_we;
    logic [mem_drv_pkg::ADDR_BITS-1:0] mem_waddr;
    logic [mem_drv_pkg::LINE_BITS-1:0] mem_wdata;
    logic [mem_drv_pkg::LINE_BITS-1:0] lines [mem_drv_pkg::MEM_LINES];

    // ==================================================
    // Request queues
    // ==================================================

    // Every valid pulse is taken, the almost-full margin guarantees room
    req_fifo #(.WIDTH(mem_drv_pkg::REQ_BITS)) read_q
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .push        (c0_tx_valid),
        .push_word   (c0_tx_req),
        .pop         (do_read),
        .head_word   (rd_head),
        .empty       (rd_empty),
        .almost_full (c0_tx_almost_full)
    );

    // Write entries keep the line data beside the request word
    req_fifo #(.WIDTH(mem_drv_pkg::REQ_BITS + mem_drv_pkg::LINE_BITS)) write_q
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .push        (c1_tx_valid),
        .push_word   ({c1_tx_req, c1_tx_data}),
        .pop         (do_write),
        .head_word   (wr_head),
        .empty       (wr_empty),
        .almost_full (c1_tx_almost_full)
    );

    // Unpack the queue heads
    assign rd_order = rd_head[mem_drv_pkg::REQ_BITS-1];
    assign rd_addr  = rd_head[mem_drv_pkg::TAG_BITS +: mem_drv_pkg::ADDR_BITS];
    assign rd_tag   = rd_head[mem_drv_pkg::TAG_BITS-1:0];

    // The write order flag is not needed since writes never pass each other
    assign wr_line = wr_head[mem_drv_pkg::LINE_BITS-1:0];
    assign wr_tag  = wr_head[mem_drv_pkg::LINE_BITS +: mem_drv_pkg::TAG_BITS];
    assign wr_addr = wr_head[mem_drv_pkg::LINE_BITS + mem_drv_pkg::TAG_BITS +:
                             mem_drv_pkg::ADDR_BITS];

    // ==================================================
    // Arbitration
    // ==================================================

    // An ordered read waits until every earlier write has left the write queue
    assign rd_can = ~sweeping & ~rd_empty & ~(rd_order & ~wr_empty);
    assign wr_can = ~sweeping & ~wr_empty;

    // One array operation per cycle, with the turn flag breaking ties
    assign do_read  = rd_can & (~wr_can | read_first);
    assign do_write = wr_can & ~do_read;

    // Clear sweep and turn flag
    // Requests keep queuing during the sweep and almost-full still governs rdy
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            sweeping   <= 1'b1;
            sweep_addr <= '0;
            read_first <= 1'b1;
        end
        else
        begin
            if (sweeping)
            begin
                sweep_addr <= sweep_addr + 1'b1;
                if (sweep_addr == mem_drv_pkg::ADDR_BITS'(mem_drv_pkg::MEM_LINES - 1))
                begin
                    sweeping <= 1'b0;
                end
            end
            // Priority only flips when both sides actually competed
            if (rd_can && wr_can)
            begin
                read_first <= ~read_first;
            end
        end
    end

    // ==================================================
    // Line storage and responses
    // ==================================================

    // The sweep and client writes share the single write path
    assign mem_we    = sweeping | do_write;
    assign mem_waddr = sweeping ? sweep_addr : wr_addr;
    assign mem_wdata = sweeping ? '0 : wr_line;

    // Reads and writes never share a cycle, so there is no collision to resolve
    always_ff @(posedge clk)
    begin
        if (mem_we)
        begin
            lines[mem_waddr] <= mem_wdata;
        end
        if (do_read)
        begin
            rd_rsp_data <= lines[rd_addr];
            rd_rsp_tag  <= rd_tag;
        end
        if (do_write)
        begin
            wr_ack_tag <= wr_tag;
        end
    end

    // Response strobes one cycle after service
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_rsp_valid <= 1'b0;
            wr_ack       <= 1'b0;
        end
        else
        begin
            rd_rsp_valid <= do_read;
            wr_ack       <= do_write;
        end
    end

endmodule

/* rtl/mem_drv_top.sv */
/* Module mem_drv_top: read and write request encoders feeding
   the behavioural line memory */
`timescale 1ns/1ps

module mem_drv_top
(
    input  logic                              clk,
    input  logic                              reset_n,

    // Read request
    input  logic [mem_drv_pkg::ADDR_BITS-1:0] rd_req_addr,
    input  logic                              rd_req_check_order,
    input  logic                              rd_req_enable,
    output logic                              rd_req_rdy,

    // Read response
    output logic [mem_drv_pkg::LINE_BITS-1:0] rd_rsp_data,
    output logic [mem_drv_pkg::TAG_BITS-1:0]  rd_rsp_tag,
    output logic                              rd_rsp_valid,

    // Write request
    input  logic [mem_drv_pkg::ADDR_BITS-1:0] wr_addr,
    input  logic [mem_drv_pkg::LINE_BITS-1:0] wr_data,
    input  logic                              wr_check_order,
    input  logic                              wr_enable,
    output logic                              wr_rdy,

    // Write acknowledge, one write completes per pulse
    output logic                              wr_ack,
    output logic [mem_drv_pkg::TAG_BITS-1:0]  wr_ack_tag
);

    // Read channel c0
    logic                              c0_tx_valid;
    logic [mem_drv_pkg::REQ_BITS-1:0]  c0_tx_req;
    logic                              c0_tx_almost_full;

    // Write channel c1
    logic                              c1_tx_valid;
    logic [mem_drv_pkg::REQ_BITS-1:0]  c1_tx_req;
    logic [mem_drv_pkg::LINE_BITS-1:0] c1_tx_data;
    logic                              c1_tx_almost_full;

    // ==================================================
    // Client side encoders
    // ==================================================

    rd_req_encoder rd_enc
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .addr        (rd_req_addr),
        .check_order (rd_req_check_order),
        .enable      (rd_req_enable),
        .rdy         (rd_req_rdy),
        .almost_full (c0_tx_almost_full),
        .tx_valid    (c0_tx_valid),
        .tx_req      (c0_tx_req)
    );

    wr_req_encoder wr_enc
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .addr        (wr_addr),
        .data        (wr_data),
        .check_order (wr_check_order),
        .enable      (wr_enable),
        .rdy         (wr_rdy),
        .almost_full (c1_tx_almost_full),
        .tx_valid    (c1_tx_valid),
        .tx_req      (c1_tx_req),
        .tx_data     (c1_tx_data)
    );

    // ==================================================
    // Platform side memory
    // ==================================================

    fiu_line_memory line_mem
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .c0_tx_valid       (c0_tx_valid),
        .c0_tx_req         (c0_tx_req),
        .c0_tx_almost_full (c0_tx_almost_full),
        .c1_tx_valid       (c1_tx_valid),
        .c1_tx_req         (c1_tx_req),
        .c1_tx_data        (c1_tx_data),
        .c1_tx_almost_full (c1_tx_almost_full),
        .rd_rsp_valid      (rd_rsp_valid),
        .rd_rsp_data       (rd_rsp_data),
        .rd_rsp_tag        (rd_rsp_tag),
        .wr_ack            (wr_ack),
        .wr_ack_tag        (wr_ack_tag)
    );

endmodule

/* verification/mem_drv_model.svh */
/* Reference line memory, per-tag records of outstanding requests
   and the response check tasks used by the memory driver testbench */
`ifndef MEM_DRV_MODEL_SVH
`define MEM_DRV_MODEL_SVH

localparam int TAG_SPAN = 1 << mem_drv_pkg::TAG_BITS;

// Memory contents as the client has written them, updated at acceptance
logic [mem_drv_pkg::LINE_BITS-1:0] model_mem [mem_drv_pkg::MEM_LINES];
// Accepted writes per line that are not acknowledged yet
int pend_writes [mem_drv_pkg::MEM_LINES];
// Running count of accepted writes per line
int write_seq [mem_drv_pkg::MEM_LINES];

// Outstanding requests are never more than one tag span apart
logic [mem_drv_pkg::LINE_BITS-1:0] exp_rd_data [TAG_SPAN];
logic [mem_drv_pkg::ADDR_BITS-1:0] exp_rd_addr [TAG_SPAN];
int                                exp_rd_seq  [TAG_SPAN];
logic                              exp_rd_safe [TAG_SPAN];
logic [mem_drv_pkg::ADDR_BITS-1:0] exp_wr_addr [TAG_SPAN];

int    rd_accepted;
int    rd_responded;
int    wr_accepted;
int    wr_acked;
int    error_count;
int    check_count;
string test_name;

task automatic clear_model();
    for (int i = 0; i < mem_drv_pkg::MEM_LINES; i++)
    begin
        model_mem[i]   = '0;
        pend_writes[i] = 0;
        write_seq[i]   = 0;
    end
    rd_accepted  = 0;
    rd_responded = 0;
    wr_accepted  = 0;
    wr_acked     = 0;
    error_count  = 0;
    check_count  = 0;
endtask

task automatic record_write(input logic [mem_drv_pkg::ADDR_BITS-1:0] addr,
                            input logic [mem_drv_pkg::LINE_BITS-1:0] data);
    logic [mem_drv_pkg::TAG_BITS-1:0] tag;
    tag = mem_drv_pkg::TAG_BITS'(wr_accepted);
    model_mem[addr] = data;
    pend_writes[addr]++;
    write_seq[addr]++;
    exp_wr_addr[tag] = addr;
    wr_accepted++;
endtask

// An unordered read may race an earlier write that is still queued
task automatic record_read(input logic [mem_drv_pkg::ADDR_BITS-1:0] addr,
                           input logic order);
    logic [mem_drv_pkg::TAG_BITS-1:0] tag;
    tag = mem_drv_pkg::TAG_BITS'(rd_accepted);
    exp_rd_data[tag] = model_mem[addr];
    exp_rd_addr[tag] = addr;
    exp_rd_seq[tag]  = write_seq[addr];
    exp_rd_safe[tag] = order || (pend_writes[addr] == 0);
    rd_accepted++;
endtask

task automatic check_read_response(input logic [mem_drv_pkg::LINE_BITS-1:0] data,
                                   input logic [mem_drv_pkg::TAG_BITS-1:0] tag);
    logic [mem_drv_pkg::TAG_BITS-1:0]  exp_tag;
    logic [mem_drv_pkg::ADDR_BITS-1:0] addr;
    exp_tag = mem_drv_pkg::TAG_BITS'(rd_responded);
    if (rd_responded >= rd_accepted)
    begin
        error_count++;
        $display("Unexpected read response with tag %0d in test %s", tag, test_name);
    end
    else
    begin
        check_count++;
        if (tag !== exp_tag)
        begin
            error_count++;
            $display("Mismatch %s rd_rsp_tag: expected %0d, actual %0d",
                     test_name, exp_tag, tag);
        end
        // A later write to the same line may land before the read
        addr = exp_rd_addr[exp_tag];
        if (exp_rd_safe[exp_tag] && write_seq[addr] == exp_rd_seq[exp_tag])
        begin
            check_count++;
            if (data !== exp_rd_data[exp_tag])
            begin
                error_count++;
                $display("Mismatch %s rd_rsp_data: expected %h, actual %h",
                         test_name, exp_rd_data[exp_tag], data);
            end
        end
        rd_responded++;
    end
endtask

task automatic check_write_ack(input logic [mem_drv_pkg::TAG_BITS-1:0] tag);
    logic [mem_drv_pkg::TAG_BITS-1:0] exp_tag;
    exp_tag = mem_drv_pkg::TAG_BITS'(wr_acked);
    if (wr_acked >= wr_accepted)
    begin
        error_count++;
        $display("Unexpected write acknowledge with tag %0d in test %s", tag, test_name);
    end
    else
    begin
        check_count++;
        if (tag !== exp_tag)
        begin
            error_count++;
            $display("Mismatch %s wr_ack_tag: expected %0d, actual %0d",
                     test_name, exp_tag, tag);
        end
        // The acknowledged write is now in the array
        pend_writes[exp_wr_addr[exp_tag]]--;
        wr_acked++;
    end
endtask

`endif

/* verification/mem_drv_tb.sv */
/* Testbench mem_drv_tb: clock and reset, random client traffic,
   response checks against the reference model, watchdog and summary */
`timescale 1ns/1ps

module mem_drv_tb;

    // ==================================================
    // Run length
    // ==================================================

    localparam int N_ZERO  = 16;
    localparam int N_WRITE = 24;
    localparam int N_ORDER = 16;
    localparam int N_BURST = 40;
    localparam int N_BUSY  = 30;
    localparam int N_MIX   = 300;

    // Upper bound on enable strobes over all tests
    localparam int ISSUED = N_ZERO + 2 * N_WRITE + 8 * N_ORDER + 2 * N_BURST
                          + 2 * N_BUSY + 2 * N_MIX;
    localparam int CYCLE_LIMIT = 40 * ISSUED + 500;

    logic                              clk;
    logic                              reset_n;
    logic [mem_drv_pkg::ADDR_BITS-1:0] rd_req_addr;
    logic                              rd_req_check_order;
    logic                              rd_req_enable;
    logic                              rd_req_rdy;
    logic [mem_drv_pkg::LINE_BITS-1:0] rd_rsp_data;
    logic [mem_drv_pkg::TAG_BITS-1:0]  rd_rsp_tag;
    logic                              rd_rsp_valid;
    logic [mem_drv_pkg::ADDR_BITS-1:0] wr_addr;
    logic [mem_drv_pkg::LINE_BITS-1:0] wr_data;
    logic                              wr_check_order;
    logic                              wr_enable;
    logic                              wr_rdy;
    logic                              wr_ack;
    logic [mem_drv_pkg::TAG_BITS-1:0]  wr_ack_tag;

    integer seed;
    int     cycle_count;
    int     dropped;
    logic [mem_drv_pkg::ADDR_BITS-1:0] written [N_WRITE];

    `include "mem_drv_model.svh"

    mem_drv_top dut_i
    (
        .clk                (clk),
        .reset_n            (reset_n),
        .rd_req_addr        (rd_req_addr),
        .rd_req_check_order (rd_req_check_order),
        .rd_req_enable      (rd_req_enable),
        .rd_req_rdy         (rd_req_rdy),
        .rd_rsp_data        (rd_rsp_data),
        .rd_rsp_tag         (rd_rsp_tag),
        .rd_rsp_valid       (rd_rsp_valid),
        .wr_addr            (wr_addr),
        .wr_data            (wr_data),
        .wr_check_order     (wr_check_order),
        .wr_enable          (wr_enable),
        .wr_rdy             (wr_rdy),
        .wr_ack             (wr_ack),
        .wr_ack_tag         (wr_ack_tag)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog on the total run length
    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: responses did not drain within %0d cycles", CYCLE_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================

    function automatic logic [mem_drv_pkg::ADDR_BITS-1:0] random_addr(
        input logic [mem_drv_pkg::ADDR_BITS-1:0] mask);
        return mem_drv_pkg::ADDR_BITS'($random(seed)) & mask;
    endfunction

    function automatic logic [mem_drv_pkg::LINE_BITS-1:0] random_line();
        return mem_drv_pkg::LINE_BITS'({$random(seed), $random(seed)});
    endfunction

    function automatic logic random_bit();
        return 1'($random(seed));
    endfunction

    // One clock: check outputs, record what the DUT accepts, drive the next inputs
    task automatic clock_step(input logic                              next_rd_en,
                              input logic [mem_drv_pkg::ADDR_BITS-1:0] next_rd_addr,
                              input logic                              next_rd_order,
                              input logic                              next_wr_en,
                              input logic [mem_drv_pkg::ADDR_BITS-1:0] next_wr_addr,
                              input logic [mem_drv_pkg::LINE_BITS-1:0] next_wr_data);
        @(posedge clk);
        // Responses are checked before new requests are recorded
        // so a finished write has already left the pending counts
        if (rd_rsp_valid)
        begin
            check_read_response(rd_rsp_data, rd_rsp_tag);
        end
        if (wr_ack)
        begin
            check_write_ack(wr_ack_tag);
        end
        // Same enable and rdy values the encoders sample on this edge
        if (wr_enable && wr_rdy)
        begin
            record_write(wr_addr, wr_data);
        end
        if (rd_req_enable && rd_req_rdy)
        begin
            record_read(rd_req_addr, rd_req_check_order);
        end
        if ((wr_enable && !wr_rdy) || (rd_req_enable && !rd_req_rdy))
        begin
            dropped++;
        end
        rd_req_enable      <= next_rd_en;
        rd_req_addr        <= next_rd_addr;
        rd_req_check_order <= next_rd_order;
        wr_enable          <= next_wr_en;
        wr_addr            <= next_wr_addr;
        wr_data            <= next_wr_data;
        wr_check_order     <= random_bit();
    endtask

    task automatic idle_cycle();
        clock_step(1'b0, '0, 1'b0, 1'b0, '0, '0);
    endtask

    // Wait for every accepted request, then watch for stray responses
    task automatic drain_responses();
        idle_cycle();
        while (rd_responded < rd_accepted || wr_acked < wr_accepted)
        begin
            idle_cycle();
        end
        repeat (20) idle_cycle();
    endtask

    // ==================================================
    // Tests
    // ==================================================

    task automatic zero_read_sweep();
        int issued;
        issued = 0;
        test_name = "zero_read";
        while (issued < N_ZERO)
        begin
            if (rd_req_rdy)
            begin
                clock_step(1'b1, random_addr('1), random_bit(), 1'b0, '0, '0);
                issued++;
            end
            else
            begin
                idle_cycle();
            end
        end
        drain_responses();
    endtask

    task automatic write_then_read();
        test_name = "write_read";
        for (int i = 0; i < N_WRITE; i++)
        begin
            written[i] = random_addr('1);
            clock_step(1'b0, '0, 1'b0, 1'b1, written[i], random_line());
        end
        drain_responses();
        for (int i = 0; i < N_WRITE; i++)
        begin
            clock_step(1'b1, written[i], 1'b0, 1'b0, '0, '0);
        end
        drain_responses();
    endtask

    task automatic ordered_read_after_write();
        logic [mem_drv_pkg::ADDR_BITS-1:0] addr;
        test_name = "ordered_read";
        for (int i = 0; i < N_ORDER; i++)
        begin
            addr = random_addr('1);
            // Reads beside writes share the port and leave a write backlog
            repeat (2)
            begin
                clock_step(1'b1, random_addr('1), 1'b0,
                           1'b1, random_addr('1), random_line());
            end
            // Further writes keep that backlog ahead of the target write
            repeat (2)
            begin
                clock_step(1'b0, '0, 1'b0, 1'b1, random_addr('1), random_line());
            end
            // The ordered read reaches its queue head while the target write still waits
            clock_step(1'b0, '0, 1'b0, 1'b1, addr, random_line());
            clock_step(1'b1, addr, 1'b1, 1'b0, '0, '0);
            drain_responses();
        end
    endtask

    // Two requests per cycle against one array port fill the queues
    task automatic burst_both_sides();
        int busy_seen;
        busy_seen = 0;
        test_name = "burst";
        repeat (N_BURST)
        begin
            if (!rd_req_rdy || !wr_rdy)
            begin
                busy_seen++;
            end
            clock_step(rd_req_rdy, random_addr('1), random_bit(),
                       wr_rdy, random_addr('1), random_line());
        end
        drain_responses();
        if (busy_seen == 0)
        begin
            error_count++;
            $display("Burst of enables never brought rdy low");
        end
    endtask

    task automatic enables_while_busy();
        int start;
        start = dropped;
        test_name = "busy_enable";
        repeat (N_BUSY)
        begin
            clock_step(1'b1, random_addr('1), 1'b0, 1'b1, random_addr('1), random_line());
        end
        drain_responses();
        if (dropped == start)
        begin
            error_count++;
            $display("No enable was strobed while rdy was low");
        end
    endtask

    // Sixteen lines only, so ordered reads often meet queued writes
    task automatic mixed_random();
        test_name = "mixed";
        repeat (N_MIX)
        begin
            clock_step(rd_req_rdy & random_bit(),
                       random_addr(mem_drv_pkg::ADDR_BITS'(15)), random_bit(),
                       wr_rdy & random_bit(),
                       random_addr(mem_drv_pkg::ADDR_BITS'(15)), random_line());
        end
        drain_responses();
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial
    begin
        seed = 39;
        dropped = 0;
        clear_model();
        test_name          = "reset";
        reset_n            = 1'b0;
        rd_req_addr        = '0;
        rd_req_check_order = 1'b0;
        rd_req_enable      = 1'b0;
        wr_addr            = '0;
        wr_data            = '0;
        wr_check_order     = 1'b0;
        wr_enable          = 1'b0;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;

        zero_read_sweep();
        write_then_read();
        ordered_read_after_write();
        burst_both_sides();
        enables_while_busy();
        mixed_random();

        if (rd_responded != rd_accepted || wr_acked != wr_accepted)
        begin
            error_count++;
            $display("Response counts differ from accepted request counts");
        end
        $display("Summary: %0d checks, %0d errors, reads %0d of %0d, writes %0d of %0d",
                 check_count, error_count, rd_responded, rd_accepted, wr_acked, wr_accepted);
        if (error_count == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* mem_drv_top.f */
+incdir+verification
rtl/mem_drv_pkg.sv
rtl/req_fifo.sv
rtl/rd_req_encoder.sv
rtl/wr_req_encoder.sv
rtl/fiu_line_memory.sv
rtl/mem_drv_top.sv
verification/mem_drv_tb.sv
